// ==== Bender.yml ====
package:
  name: tiny16

sources:
  - src/tiny16_pkg.sv
  - src/tiny16_stage_counter.sv
  - src/tiny16_control.sv
  - src/tiny16_regfile.sv
  - src/tiny16_execute.sv
  - src/tiny16.sv
  - target: test
    files:
      - tb/tiny16_properties.sv
      - tb/tb_tiny16.sv

// ==== src/tiny16.sv ====
`timescale 1ns/1ps
`default_nettype none

module tiny16 #(
    parameter tiny16_pkg::word_t reset_pc = 16'h0000
) (
    input  logic              clk,
    input  logic              reset,
    output tiny16_pkg::word_t address,
    input  tiny16_pkg::word_t data_in,
    output tiny16_pkg::word_t data_out,
    output logic              rd,
    output logic              wr,
    input  logic              ready,
    output logic              hlt,
    output logic              error
);
    import tiny16_pkg::*;

    stage_e     stage;
    logic       advance;
    reg_idx_t   rf_rd_idx;
    reg_idx_t   rf_wr_idx;
    logic       rf_we;
    logic       rf_pc_we;
    logic [1:0] rf_lane;
    logic [1:0] rf_src;
    logic [1:0] ex_op;
    logic       flag_we;
    imm10_t     imm10;
    offset8_t   offset8;
    logic [2:0] cond_mask;
    logic       cond_neg;
    word_t      rf_wr_data;
    word_t      rf_rd_data;
    word_t      rf_rd_data2;
    word_t      pc;
    word_t      pc_next;
    word_t      ex_result;
    word_t      eff_addr;

    // fetch uses the PC, load and store the computed address
    assign address  = (stage == FETCH) ? pc : eff_addr;
    assign data_out = rf_rd_data2;

    always_comb begin
        case (rf_src)
            SRC_MEM:  rf_wr_data = data_in;
            SRC_EXEC: rf_wr_data = ex_result;
            SRC_REG:  rf_wr_data = rf_rd_data;
            // mvi byte in both lanes, the lane select picks one
            default:  rf_wr_data = {offset8, offset8};
        endcase
    end

    tiny16_stage_counter u_stage (
        .clk     (clk),
        .reset   (reset),
        .advance (advance),
        .stage   (stage)
    );

    tiny16_control u_control (
        .clk       (clk),
        .reset     (reset),
        .stage     (stage),
        .data_in   (data_in),
        .ready     (ready),
        .advance   (advance),
        .rd        (rd),
        .wr        (wr),
        .hlt       (hlt),
        .error     (error),
        .rf_rd_idx (rf_rd_idx),
        .rf_wr_idx (rf_wr_idx),
        .rf_we     (rf_we),
        .rf_pc_we  (rf_pc_we),
        .rf_lane   (rf_lane),
        .rf_src    (rf_src),
        .ex_op     (ex_op),
        .flag_we   (flag_we),
        .imm10     (imm10),
        .offset8   (offset8),
        .cond_mask (cond_mask),
        .cond_neg  (cond_neg)
    );

    tiny16_regfile #(
        .reset_pc (reset_pc)
    ) u_regfile (
        .clk      (clk),
        .reset    (reset),
        .rd_idx   (rf_rd_idx),
        .wr_idx   (rf_wr_idx),
        .we       (rf_we),
        .lane     (rf_lane),
        .wr_data  (rf_wr_data),
        .pc_we    (rf_pc_we),
        .pc_next  (pc_next),
        .rd_data  (rf_rd_data),
        .rd_data2 (rf_rd_data2),
        .pc       (pc)
    );

    // the first read port serves both as adi operand and as address base
    tiny16_execute u_execute (
        .clk       (clk),
        .reset     (reset),
        .op        (ex_op),
        .flag_we   (flag_we),
        .src_data  (rf_rd_data),
        .base_data (rf_rd_data),
        .pc        (pc),
        .imm10     (imm10),
        .offset8   (offset8),
        .cond_mask (cond_mask),
        .cond_neg  (cond_neg),
        .result    (ex_result),
        .eff_addr  (eff_addr),
        .pc_next   (pc_next)
    );

endmodule

`default_nettype wire

// ==== src/tiny16_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module tiny16_control (
    input  logic                 clk,
    input  logic                 reset,
    input  tiny16_pkg::stage_e   stage,
    input  tiny16_pkg::word_t    data_in,
    input  logic                 ready,
    output logic                 advance,
    output logic                 rd,
    output logic                 wr,
    output logic                 hlt,
    output logic                 error,
    output tiny16_pkg::reg_idx_t rf_rd_idx,
    output tiny16_pkg::reg_idx_t rf_wr_idx,
    output logic                 rf_we,
    output logic                 rf_pc_we,
    output logic [1:0]           rf_lane,
    output logic [1:0]           rf_src,
    output logic [1:0]           ex_op,
    output logic                 flag_we,
    output tiny16_pkg::imm10_t   imm10,
    output tiny16_pkg::offset8_t offset8,
    output logic [2:0]           cond_mask,
    output logic                 cond_neg
);
    import tiny16_pkg::*;

    word_t      instr;
    run_state_e state;
    logic       started;
    logic       active;
    logic       bus_stage;
    logic [3:0] opcode;
    reg_idx_t   dst;
    reg_idx_t   src;
    logic       is_halt;
    logic       is_nop;
    logic       is_br;
    logic       is_mvi;
    logic       is_load;
    logic       is_store;
    logic       is_movrr;
    logic       is_adi;
    logic       illegal;

    assign opcode = instr[OPC_LSB +: 4];
    assign dst    = instr[DST_LSB +: 2];
    assign src    = instr[SRC_LSB +: 2];

    assign is_halt  = (instr == INSTR_HALT);
    assign is_nop   = (instr == INSTR_NOP);
    assign is_br    = (opcode == OP_BR);
    assign is_mvi   = (opcode == OP_MVI) && !instr[MODE_BIT];
    assign is_load  = (opcode == OP_LOAD);
    assign is_store = (opcode == OP_STORE);
    assign is_movrr = (opcode == OP_MOVRR);
    assign is_adi   = (opcode == OP_ADI);
    assign illegal  = !(is_halt || is_nop || is_br || is_mvi ||
                        is_load || is_store || is_movrr || is_adi);

    assign imm10     = {dst, instr[VAL_LSB +: 8]};
    assign offset8   = instr[VAL_LSB +: 8];
    assign cond_mask = instr[2:0];
    assign cond_neg  = instr[MODE_BIT];

    // idle for one cycle after reset, then fetch
    assign active    = started && (state == RUNNING);
    assign bus_stage = (stage == FETCH) || ((stage == EXECUTE) && (is_load || is_store));
    assign advance   = active && (!bus_stage || ready);

    assign rd = active && ((stage == FETCH) || ((stage == EXECUTE) && is_load));
    assign wr = active && (stage == EXECUTE) && is_store;

    assign hlt   = (state != RUNNING);
    assign error = (state == FAULTED);

    assign rf_pc_we = active && (stage == DECODE) && !is_halt && !illegal;
    // load data is written in the cycle memory answers
    assign rf_we = active && (((stage == WRITEBACK) && (is_mvi || is_movrr || is_adi)) ||
                              ((stage == EXECUTE) && is_load && ready));
    assign flag_we = active && (stage == WRITEBACK) && is_adi;

    always_comb begin
        rf_rd_idx = src;
        rf_wr_idx = dst;
        rf_lane   = LANE_BOTH;
        rf_src    = SRC_REG;
        ex_op     = EX_ADDR;
        if (is_store) begin
            // base on the first port, store data on the second
            rf_rd_idx = dst;
            rf_wr_idx = src;
        end else if (is_load) begin
            rf_src = SRC_MEM;
        end else if (is_adi) begin
            rf_wr_idx = src;
            rf_src    = SRC_EXEC;
            ex_op     = EX_ADI;
        end else if (is_mvi) begin
            rf_wr_idx = src;
            rf_src    = SRC_IMM;
            rf_lane   = instr[HI_BIT] ? LANE_HI : LANE_LO;
        end else if (is_br) begin
            ex_op = EX_BRANCH;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            started <= 1'b0;
            state   <= RUNNING;
        end else begin
            started <= 1'b1;
            // stop decision at the end of DECODE, held until reset
            if (active && (stage == DECODE)) begin
                if (illegal) begin
                    state <= FAULTED;
                end else if (is_halt) begin
                    state <= HALTED;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd && ready && (stage == FETCH)) begin
            instr <= data_in;
        end
    end

endmodule

`default_nettype wire

// ==== src/tiny16_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module tiny16_execute (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [1:0]           op,
    input  logic                 flag_we,
    input  tiny16_pkg::word_t    src_data,
    input  tiny16_pkg::word_t    base_data,
    input  tiny16_pkg::word_t    pc,
    input  tiny16_pkg::imm10_t   imm10,
    input  tiny16_pkg::offset8_t offset8,
    input  logic [2:0]           cond_mask,
    input  logic                 cond_neg,
    output tiny16_pkg::word_t    result,
    output tiny16_pkg::word_t    eff_addr,
    output tiny16_pkg::word_t    pc_next
);
    import tiny16_pkg::*;

    word_t      imm_ext;
    word_t      off_ext;
    logic       carry;
    logic       flag_c;
    logic       flag_z;
    logic       flag_n;
    logic [2:0] masked;
    logic       taken;

    assign imm_ext = {{6{imm10[9]}}, imm10};
    assign off_ext = {{8{offset8[7]}}, offset8};

    // adi sum with carry out of bit 15
    assign {carry, result} = {1'b0, src_data} + {1'b0, imm_ext};

    assign eff_addr = base_data + off_ext;

    // mask bit 2 tests c, bit 1 z, bit 0 n
    assign masked = cond_mask & {flag_c, flag_z, flag_n};
    assign taken  = (|masked) ^ cond_neg;

    // target relative to the branch's own address
    assign pc_next = ((op == EX_BRANCH) && taken) ? pc + off_ext : pc + 16'd1;

    always_ff @(posedge clk) begin
        if (!reset) begin
            flag_c <= 1'b0;
            flag_z <= 1'b0;
            flag_n <= 1'b0;
        end else if (flag_we) begin
            flag_c <= carry;
            flag_z <= (result == 16'h0000);
            flag_n <= result[15];
        end
    end

endmodule

`default_nettype wire

// ==== src/tiny16_pkg.sv ====
`default_nettype none

package tiny16_pkg;

    // data, address and instruction word
    typedef logic [15:0] word_t;
    typedef logic [1:0]  reg_idx_t;
    // {dst field, high byte}, signed
    typedef logic [9:0]  imm10_t;
    typedef logic [7:0]  offset8_t;

    localparam reg_idx_t REG_A  = 2'd0;
    localparam reg_idx_t REG_W  = 2'd1;
    localparam reg_idx_t REG_X  = 2'd2;
    localparam reg_idx_t REG_PC = 2'd3;

    // four-bit opcode field, bits 7:4
    typedef enum logic [3:0] {
        OP_BR    = 4'd1,
        OP_MVI   = 4'd3,
        OP_LOAD  = 4'd4,
        OP_STORE = 4'd5,
        OP_MOVRR = 4'd6,
        OP_ADI   = 4'd7
    } opcode_e;

    typedef enum logic [3:0] {
        FETCH     = 4'b0001,
        DECODE    = 4'b0010,
        EXECUTE   = 4'b0100,
        WRITEBACK = 4'b1000
    } stage_e;

    typedef enum logic [1:0] {
        RUNNING,
        HALTED,
        FAULTED
    } run_state_e;

    localparam word_t INSTR_HALT = 16'h0000;
    localparam word_t INSTR_NOP  = 16'h0001;

    // field positions in the instruction word
    localparam int OPC_LSB  = 4;
    localparam int DST_LSB  = 2;
    localparam int SRC_LSB  = 0;
    localparam int VAL_LSB  = 8;
    // br invert bit, must be zero for mvi
    localparam int MODE_BIT = 3;
    // mvi byte select
    localparam int HI_BIT   = 2;

    // byte enables of a register write
    localparam logic [1:0] LANE_LO   = 2'b01;
    localparam logic [1:0] LANE_HI   = 2'b10;
    localparam logic [1:0] LANE_BOTH = 2'b11;

    // register write data source
    localparam logic [1:0] SRC_MEM  = 2'd0;
    localparam logic [1:0] SRC_EXEC = 2'd1;
    localparam logic [1:0] SRC_REG  = 2'd2;
    localparam logic [1:0] SRC_IMM  = 2'd3;

    // execute unit operation
    localparam logic [1:0] EX_ADI    = 2'd0;
    localparam logic [1:0] EX_ADDR   = 2'd1;
    localparam logic [1:0] EX_BRANCH = 2'd2;

endpackage

`default_nettype wire

// ==== src/tiny16_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module tiny16_regfile #(
    parameter tiny16_pkg::word_t reset_pc = 16'h0000
) (
    input  logic                 clk,
    input  logic                 reset,
    input  tiny16_pkg::reg_idx_t rd_idx,
    input  tiny16_pkg::reg_idx_t wr_idx,
    input  logic                 we,
    input  logic [1:0]           lane,
    input  tiny16_pkg::word_t    wr_data,
    input  logic                 pc_we,
    input  tiny16_pkg::word_t    pc_next,
    output tiny16_pkg::word_t    rd_data,
    output tiny16_pkg::word_t    rd_data2,
    output tiny16_pkg::word_t    pc
);
    import tiny16_pkg::*;

    word_t regs [4];

    assign rd_data = regs[rd_idx];
    // second read port follows the write index, used for store data
    assign rd_data2 = regs[wr_idx];
    assign pc = regs[REG_PC];

    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
            regs[REG_PC] <= reset_pc;
        end else begin
            if (pc_we) begin
                regs[REG_PC] <= pc_next;
            end
            // byte lanes, mvi touches only one of them
            if (we && lane[0]) begin
                regs[wr_idx][7:0] <= wr_data[7:0];
            end
            if (we && lane[1]) begin
                regs[wr_idx][15:8] <= wr_data[15:8];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/tiny16_stage_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tiny16_stage_counter (
    input  logic               clk,
    input  logic               reset,
    input  logic               advance,
    output tiny16_pkg::stage_e stage
);
    import tiny16_pkg::*;

    logic [3:0] rotated;

    // one-hot ring, WRITEBACK wraps back to FETCH
    assign rotated = {stage[2:0], stage[3]};

    always_ff @(posedge clk) begin
        if (!reset) begin
            stage <= FETCH;
        end else if (advance) begin
            stage <= stage_e'(rotated);
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_tiny16.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tiny16;

    localparam logic [1:0]  REG_A      = 2'd0;
    localparam logic [1:0]  REG_W      = 2'd1;
    localparam logic [1:0]  REG_X      = 2'd2;
    localparam logic [15:0] WORD_HALT  = 16'h0000;
    localparam logic [15:0] WORD_NOP   = 16'h0001;
    localparam int          HALT_LIMIT = 2000;

    logic        clk;
    logic        reset;
    logic        ready;
    logic [15:0] address;
    logic [15:0] data_in;
    logic [15:0] data_out;
    logic        rd;
    logic        wr;
    logic        hlt;
    logic        error;

    // behavioral memory and the reference machine state
    logic [15:0] mem [256];
    logic [15:0] model_mem [256];
    logic [15:0] model_reg [4];
    logic        flag_c;
    logic        flag_z;
    logic        flag_n;
    logic        live;
    logic [7:0]  emit_addr;
    logic [7:0]  slot;

    logic        stall_en;
    logic [1:0]  wait_left;
    logic [1:0]  wait_table [1024];
    logic [9:0]  draw_idx;

    string       cur_name;
    string       first_msg;
    int          mism;
    int          tests_run;
    int          tests_failed;

    tiny16 #(
        .reset_pc (16'h0000)
    ) uut (
        .clk      (clk),
        .reset    (reset),
        .address  (address),
        .data_in  (data_in),
        .data_out (data_out),
        .rd       (rd),
        .wr       (wr),
        .ready    (ready),
        .hlt      (hlt),
        .error    (error)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // asynchronous read, write on the completing edge
    assign data_in = mem[address[7:0]];

    always @(posedge clk) begin
        if (wr && ready) begin
            mem[address[7:0]] <= data_out;
        end
        if (!stall_en) begin
            ready     <= 1'b1;
            wait_left <= 2'd0;
        end else if ((rd || wr) && ready) begin
            wait_left <= wait_table[draw_idx];
            ready     <= (wait_table[draw_idx] == 2'd0);
            draw_idx  <= draw_idx + 10'd1;
        end else if ((rd || wr) && (wait_left != 2'd0)) begin
            wait_left <= wait_left - 2'd1;
            ready     <= (wait_left == 2'd1);
        end
    end

    function automatic logic [15:0] sext8(input logic [7:0] v);
        return {{8{v[7]}}, v};
    endfunction

    function automatic logic [15:0] sext10(input logic [9:0] v);
        return {{6{v[9]}}, v};
    endfunction

    function automatic logic [15:0] fill_word(input logic [7:0] a);
        return {~a, a};
    endfunction

    task automatic emit(input logic [15:0] w);
        mem[emit_addr] = w;
        model_mem[emit_addr] = w;
        emit_addr++;
    endtask

    task automatic preload(input logic [7:0] a, input logic [15:0] v);
        mem[a] = v;
        model_mem[a] = v;
    endtask

    task automatic emit_mvi(input logic [1:0] r, input logic hi, input logic [7:0] v);
        if (live && hi) begin
            model_reg[r][15:8] = v;
        end else if (live) begin
            model_reg[r][7:0] = v;
        end
        emit({v, 4'h3, 1'b0, hi, r});
    endtask

    task automatic emit_adi(input logic [1:0] r, input logic [9:0] imm);
        logic [16:0] sum;
        sum = {1'b0, model_reg[r]} + {1'b0, sext10(imm)};
        if (live) begin
            model_reg[r] = sum[15:0];
            flag_c = sum[16];
            flag_z = (sum[15:0] == 16'h0000);
            flag_n = sum[15];
        end
        emit({imm[7:0], 4'h7, imm[9:8], r});
    endtask

    task automatic emit_store(input logic [1:0] base, input logic [1:0] src,
                              input logic [7:0] off);
        logic [15:0] ea;
        ea = model_reg[base] + sext8(off);
        if (live) begin
            model_mem[ea[7:0]] = model_reg[src];
        end
        emit({off, 4'h5, base, src});
    endtask

    task automatic emit_load(input logic [1:0] dst, input logic [1:0] base,
                             input logic [7:0] off);
        logic [15:0] ea;
        ea = model_reg[base] + sext8(off);
        if (live) begin
            model_reg[dst] = model_mem[ea[7:0]];
        end
        emit({off, 4'h4, dst, base});
    endtask

    task automatic emit_move(input logic [1:0] dst, input logic [1:0] src);
        if (live) begin
            model_reg[dst] = model_reg[src];
        end
        emit({8'h00, 4'h6, dst, src});
    endtask

    // one taken path and one fall-through path, each with its own marker slot
    task automatic branch_case(input logic [2:0] mask, input logic inv);
        logic taken;
        taken = (|(mask & {flag_c, flag_z, flag_n})) ^ inv;
        emit_mvi(REG_W, 1'b0, 8'h50 + slot);
        emit({8'h03, 4'h1, inv, mask});
        live = !taken;
        emit_store(REG_X, REG_W, slot * 8'd2);
        live = 1'b1;
        emit({8'h02, 4'h1, 1'b1, 3'b000});
        live = taken;
        emit_store(REG_X, REG_W, slot * 8'd2 + 8'd1);
        live = 1'b1;
        slot++;
    endtask

    task automatic prepare_memory();
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(8'(i));
            model_mem[i] = fill_word(8'(i));
        end
        for (int r = 0; r < 4; r++) begin
            model_reg[r] = 16'h0000;
        end
        flag_c = 1'b0;
        flag_z = 1'b0;
        flag_n = 1'b0;
        live = 1'b1;
        emit_addr = 8'h00;
        slot = 8'h00;
    endtask

    task automatic build_mvi_store();
        emit_mvi(REG_A, 1'b0, 8'h34);
        emit_mvi(REG_A, 1'b1, 8'h12);
        emit_mvi(REG_X, 1'b0, 8'h90);
        emit_mvi(REG_W, 1'b0, 8'hcd);
        emit_mvi(REG_W, 1'b1, 8'hab);
        emit_store(REG_X, REG_A, 8'hfc);
        emit_store(REG_X, REG_W, 8'h05);
        emit_store(REG_X, REG_X, 8'h00);
        // low byte rewrite keeps the high byte
        emit_mvi(REG_A, 1'b0, 8'h56);
        emit_store(REG_X, REG_A, 8'h01);
        emit(WORD_HALT);
    endtask

    task automatic build_adi_flags();
        emit_mvi(REG_X, 1'b0, 8'ha0);
        emit_mvi(REG_A, 1'b0, 8'h10);
        emit_adi(REG_A, 10'h1f0);
        emit_store(REG_X, REG_A, 8'h00);
        emit_adi(REG_A, 10'h3fd);
        emit_store(REG_X, REG_A, 8'h01);
        emit_mvi(REG_W, 1'b0, 8'hff);
        emit_mvi(REG_W, 1'b1, 8'hff);
        emit_adi(REG_W, 10'h002);
        emit_store(REG_X, REG_W, 8'h02);
        emit_adi(REG_W, 10'h3ff);
        emit_store(REG_X, REG_W, 8'h03);
        emit_mvi(REG_A, 1'b1, 8'h7f);
        emit_mvi(REG_A, 1'b0, 8'hff);
        emit_adi(REG_A, 10'h001);
        emit_store(REG_X, REG_A, 8'h04);
        emit_adi(REG_A, 10'h200);
        emit_store(REG_X, REG_A, 8'h05);
        emit(WORD_HALT);
    endtask

    task automatic build_branches();
        emit_mvi(REG_X, 1'b0, 8'hc0);
        emit_adi(REG_A, 10'h000);
        branch_case(3'b010, 1'b0);
        branch_case(3'b100, 1'b0);
        emit_adi(REG_A, 10'h3ff);
        branch_case(3'b001, 1'b0);
        branch_case(3'b010, 1'b1);
        // wraps to zero with carry
        emit_adi(REG_A, 10'h001);
        branch_case(3'b100, 1'b0);
        branch_case(3'b001, 1'b0);
        branch_case(3'b110, 1'b1);
        emit(WORD_HALT);
    endtask

    task automatic build_load_movrr();
        preload(8'hd0, 16'h5a3c);
        preload(8'hcf, 16'hc3a5);
        emit_mvi(REG_X, 1'b0, 8'hd0);
        emit_load(REG_A, REG_X, 8'h00);
        emit_move(REG_W, REG_A);
        emit_store(REG_X, REG_W, 8'h01);
        emit_load(REG_W, REG_X, 8'hff);
        emit_move(REG_A, REG_W);
        emit_store(REG_X, REG_A, 8'h02);
        emit(WORD_HALT);
    endtask

    task automatic build_halt_stop();
        emit_mvi(REG_X, 1'b0, 8'he0);
        emit_mvi(REG_A, 1'b0, 8'h11);
        emit(WORD_NOP);
        emit_store(REG_X, REG_A, 8'h00);
        emit(WORD_HALT);
        live = 1'b0;
        emit_store(REG_X, REG_A, 8'h01);
    endtask

    task automatic build_illegal();
        emit_mvi(REG_X, 1'b0, 8'he8);
        emit_mvi(REG_A, 1'b0, 8'h22);
        emit_store(REG_X, REG_A, 8'h00);
        emit(16'h00f0);
        live = 1'b0;
        emit_store(REG_X, REG_A, 8'h01);
        emit(WORD_HALT);
    endtask

    task automatic note_mismatch(input string what, input logic [15:0] exp,
                                 input logic [15:0] act);
        if (mism == 0) begin
            first_msg = $sformatf("FAILED %s %s: expected %h, actual %h",
                                  cur_name, what, exp, act);
        end
        mism++;
    endtask

    task automatic wait_for_halt(output logic halted);
        int cycles;
        halted = 1'b0;
        cycles = 0;
        while (!halted && (cycles < HALT_LIMIT)) begin
            @(posedge clk);
            cycles++;
            halted = hlt;
        end
    endtask

    task automatic run_test(input string name, input int id, input logic stalls);
        logic halted;
        cur_name = name;
        mism = 0;
        first_msg = "";
        @(posedge clk);
        reset <= 1'b0;
        stall_en <= stalls;
        // core is quiet two edges into reset
        repeat (2) @(posedge clk);
        prepare_memory();
        case (id)
            1: build_mvi_store();
            2: build_adi_flags();
            3: build_branches();
            4: build_load_movrr();
            5: build_halt_stop();
            default: build_illegal();
        endcase
        repeat (8) @(posedge clk);
        reset <= 1'b1;
        wait_for_halt(halted);
        if (!halted) begin
            first_msg = $sformatf("test %s: core did not halt within %0d cycles",
                                  name, HALT_LIMIT);
            mism++;
        end else begin
            repeat (2) @(posedge clk);
            for (int i = 0; i < 256; i++) begin
                assert (mem[i] === model_mem[i])
                    else note_mismatch($sformatf("mem[%02h]", i), model_mem[i], mem[i]);
            end
            assert (error === (id == 6))
                else note_mismatch("error", 16'((id == 6)), 16'(error));
        end
        tests_run++;
        if (mism == 0) begin
            $display("test %-18s ok", name);
        end else begin
            $display("%s", first_msg);
            tests_failed++;
        end
    endtask

    initial begin
        reset = 1'b0;
        ready = 1'b1;
        stall_en = 1'b0;
        wait_left = 2'd0;
        draw_idx = 10'd0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(32'h8000));
        for (int i = 0; i < 1024; i++) begin
            wait_table[i] = 2'($urandom_range(3, 0));
        end

        run_test("mvi_store", 1, 1'b0);
        run_test("adi_flags", 2, 1'b0);
        run_test("branches", 3, 1'b0);
        run_test("load_movrr", 4, 1'b0);
        run_test("halt_stop", 5, 1'b0);
        run_test("illegal_word", 6, 1'b0);
        // same programs under random ready stalls
        run_test("mvi_store_wait", 1, 1'b1);
        run_test("adi_flags_wait", 2, 1'b1);
        run_test("branches_wait", 3, 1'b1);
        run_test("load_movrr_wait", 4, 1'b1);

        $display("tests run %0d, passed %0d, failed %0d, assertion failures %0d",
                 tests_run, tests_run - tests_failed, tests_failed,
                 uut.u_props.fail_count);
        if ((tests_failed == 0) && (uut.u_props.fail_count == 0)) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tiny16_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module tiny16_properties (
    input logic               clk,
    input logic               reset,
    input logic               rd,
    input logic               wr,
    input logic               ready,
    input logic               hlt,
    input logic               error,
    input tiny16_pkg::word_t  address,
    input tiny16_pkg::stage_e stage
);
    import tiny16_pkg::*;

    int   fail_count = 0;
    logic fetch_req;

    assign fetch_req = rd && (stage == FETCH);

    // one bus request at a time
    rd_wr_exclusive: assert property (@(posedge clk) disable iff (!reset) !(rd && wr))
        else begin
            $error("rd and wr are high in the same cycle");
            fail_count++;
        end

    halted_bus_idle: assert property (@(posedge clk) disable iff (!reset) hlt |-> !(rd || wr))
        else begin
            $error("bus request while hlt is high");
            fail_count++;
        end

    error_implies_halt: assert property (@(posedge clk) disable iff (!reset) error |-> hlt)
        else begin
            $error("error is high without hlt");
            fail_count++;
        end

    // quiet first cycle after reset release
    reset_release_idle: assert property (@(posedge clk) $rose(reset) |-> !rd && !wr && !hlt && !error)
        else begin
            $error("bus or status active in the first cycle after reset");
            fail_count++;
        end

    // a request is held, with a stable address, until ready
    request_held: assert property (@(posedge clk) disable iff (!reset)
        (rd || wr) && !ready |=> (rd == $past(rd)) && (wr == $past(wr)) && $stable(address))
        else begin
            $error("bus request dropped or changed before ready");
            fail_count++;
        end

    // four cycles per instruction without stalls
    fetch_spacing: assert property (@(posedge clk) disable iff (!reset)
        fetch_req && ready ##1 (ready && !hlt) [*3] |=> fetch_req || hlt)
        else begin
            $error("next fetch did not follow four cycles after the previous one");
            fail_count++;
        end

endmodule

bind tiny16 tiny16_properties u_props (
    .clk     (clk),
    .reset   (reset),
    .rd      (rd),
    .wr      (wr),
    .ready   (ready),
    .hlt     (hlt),
    .error   (error),
    .address (address),
    .stage   (stage)
);

`default_nettype wire

// ==== tiny16.f ====
src/tiny16_pkg.sv
src/tiny16_stage_counter.sv
src/tiny16_control.sv
src/tiny16_regfile.sv
src/tiny16_execute.sv
src/tiny16.sv
tb/tiny16_properties.sv
tb/tb_tiny16.sv
